//--- dv/dmx_model.svh
`ifndef DMX_MODEL_SVH
`define DMX_MODEL_SVH

// --------------------------------------------------
// fifo contents and expected beats
// --------------------------------------------------

// one expected output beat
typedef struct packed {
    lane_vec_t weight;
    lane_vec_t act;
} exp_beat_t;

// fifo heads sit at index 0
lane_vec_t        dram_q[$];
lane_vec_t        smem_q[$];
// select paired with each smem word
logic [SEL_W-1:0] sel_q[$];
exp_beat_t        exp_q[$];

// random word in every lane
function automatic lane_vec_t rand_vec();
    lane_vec_t   v;
    logic [31:0] r;
    int          l;
    for (l = 0; l < NUM_PE; l++) begin
        r    = $urandom;
        v[l] = r[LANE_W-1:0];
    end
    return v;
endfunction

// the words one procedure consumes plus one spare per fifo
// spare stays queued once the final beat is accepted
function automatic void fill_fifos(input dmx_cfg_t cfg);
    int          n_dram;
    int          n_beats;
    logic [31:0] r;
    // spares left over from the previous procedure
    dram_q.delete();
    smem_q.delete();
    sel_q.delete();
    n_dram  = (cfg.cnt1 + 1) * (cfg.cnt2 + 1);
    n_beats = (cfg.cnt0 + 1) * n_dram;
    repeat (n_dram + 1) dram_q.push_back(rand_vec());
    repeat (n_beats + 1) begin
        r = $urandom;
        smem_q.push_back(rand_vec());
        sel_q.push_back(r[SEL_W-1:0]);
    end
endfunction

// weight held cnt0+1 beats, act unicast or one lane copied out
function automatic void build_expected(input dmx_cfg_t cfg);
    int        n_rep;
    int        n_beats;
    int        i;
    int        l;
    exp_beat_t b;
    n_rep   = cfg.cnt0 + 1;
    n_beats = n_rep * (cfg.cnt1 + 1) * (cfg.cnt2 + 1);
    for (i = 0; i < n_beats; i++) begin
        b.weight = dram_q[i / n_rep];
        if (cfg.proc == PROC_MTXV) begin
            b.act = smem_q[i];
        end else begin
            for (l = 0; l < NUM_PE; l++) begin
                b.act[l] = smem_q[i][sel_q[i]];
            end
        end
        exp_q.push_back(b);
    end
endfunction

`endif

//--- dv/dmx_tb.sv
module dmx_tb
    import dmx_pkg::*;
();

    localparam int NUM_PROCS = 24;
    // limits 0..3 on all three loops
    localparam int MAX_BEATS = 64;
    // 40 clock periods per beat, period 20
    localparam int TIMEOUT   = NUM_PROCS * MAX_BEATS * 40 * 20;

    logic             clk;
    logic             rstn;
    logic             cfg_valid_i;
    dmx_cfg_t         cfg_i;
    logic             cfg_ready_o;
    lane_vec_t        dram_data_i;
    logic             dram_empty_i;
    logic             dram_pop_o;
    lane_vec_t        smem_data_i;
    logic [SEL_W-1:0] smem_sel_i;
    logic             smem_empty_i;
    logic             smem_pop_o;
    lane_vec_t        dout_weight_o;
    lane_vec_t        dout_act_o;
    logic             valid_o;
    logic             ready_i;

    // monitor state
    logic             busy;
    logic             end_seen;
    logic             proc_done;
    logic             hold_chk;
    logic             dram_pop_seen;
    logic             smem_pop_seen;
    logic             prev_valid;
    lane_vec_t        prev_weight;
    lane_vec_t        prev_act;
    int               xfer_cnt;
    int               dram_pops;
    int               smem_pops;

    `include "dmx_model.svh"

    ipm_dmx u_dut (
        .clk           (clk),
        .rstn          (rstn),
        .cfg_valid_i   (cfg_valid_i),
        .cfg_i         (cfg_i),
        .cfg_ready_o   (cfg_ready_o),
        .dram_data_i   (dram_data_i),
        .dram_empty_i  (dram_empty_i),
        .dram_pop_o    (dram_pop_o),
        .smem_data_i   (smem_data_i),
        .smem_sel_i    (smem_sel_i),
        .smem_empty_i  (smem_empty_i),
        .smem_pop_o    (smem_pop_o),
        .dout_weight_o (dout_weight_o),
        .dout_act_o    (dout_act_o),
        .valid_o       (valid_o),
        .ready_i       (ready_i)
    );

    always begin
        #10 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "stopped at the first failure");
    endtask

    // --------------------------------------------------
    // fifo heads, random empties and ready
    // --------------------------------------------------
    always @(posedge clk) begin : drive_fifos
        logic [31:0]      r;
        lane_vec_t        junk_vec;
        logic [SEL_W-1:0] junk_sel;
        #2;
        // pops seen before this edge
        if (dram_pop_seen) begin
            junk_vec = dram_q.pop_front();
        end
        if (smem_pop_seen) begin
            junk_vec = smem_q.pop_front();
            junk_sel = sel_q.pop_front();
        end
        r = $urandom;
        // bubbles even with data queued
        dram_empty_i = (dram_q.size() == 0) || (r[1:0] == 2'd0);
        smem_empty_i = (smem_q.size() == 0) || (r[3:2] == 2'd0);
        ready_i      = (r[5:4] != 2'd0);
        dram_data_i  = (dram_q.size() > 0) ? dram_q[0] : '0;
        smem_data_i  = (smem_q.size() > 0) ? smem_q[0] : '0;
        smem_sel_i   = (sel_q.size() > 0) ? sel_q[0] : '0;
    end

    // --------------------------------------------------
    // monitor, mid cycle where everything is settled
    // --------------------------------------------------
    always @(negedge clk) begin : monitor
        exp_beat_t b;
        dram_pop_seen = 1'b0;
        smem_pop_seen = 1'b0;
        if (!rstn) begin
            hold_chk = 1'b0;
        end else begin
            assert (!(dram_pop_o && (dram_empty_i || !ready_i))) else
                abort_run($sformatf("error at %0t: dram pop while empty or stalled", $time));
            assert (!(smem_pop_o && (smem_empty_i || !ready_i))) else
                abort_run($sformatf("error at %0t: smem pop while empty or stalled", $time));
            dram_pop_seen = dram_pop_o;
            smem_pop_seen = smem_pop_o;
            if (dram_pop_o) dram_pops++;
            if (smem_pop_o) smem_pops++;
            // frozen across a stalled cycle
            if (hold_chk) begin
                assert (valid_o === prev_valid && dout_weight_o === prev_weight
                        && dout_act_o === prev_act) else
                    abort_run($sformatf("error at %0t: outputs moved with ready low", $time));
            end
            // busy until the cycle after the last transfer
            if (busy) begin
                if (end_seen) begin
                    assert (cfg_ready_o) else
                        abort_run($sformatf("error at %0t: cfg_ready_o low after end", $time));
                    busy      = 1'b0;
                    end_seen  = 1'b0;
                    proc_done = 1'b1;
                end else begin
                    assert (!cfg_ready_o) else
                        abort_run($sformatf("error at %0t: cfg_ready_o high while busy", $time));
                end
            end
            if (valid_o && ready_i) begin
                assert (exp_q.size() > 0) else
                    abort_run($sformatf("error at %0t: transfer with no beat expected", $time));
                b = exp_q.pop_front();
                assert (dout_weight_o === b.weight && dout_act_o === b.act) else
                    abort_run($sformatf(
                        "error at %0t: beat %0d weight %h act %h, expected %h %h",
                        $time, xfer_cnt, dout_weight_o, dout_act_o, b.weight, b.act));
                xfer_cnt++;
                if (exp_q.size() == 0) end_seen = 1'b1;
            end
            if (!busy && !proc_done && cfg_valid_i && cfg_ready_o) busy = 1'b1;
            hold_chk    = !ready_i;
            prev_valid  = valid_o;
            prev_weight = dout_weight_o;
            prev_act    = dout_act_o;
        end
    end

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin : main
        dmx_cfg_t    cfg;
        logic [31:0] r;
        int          p;
        int          n_dram;
        int          n_beats;
        r = $urandom(32'h4ebb);
        clk          = 1'b0;
        rstn         = 1'b0;
        cfg_valid_i  = 1'b0;
        cfg_i        = '0;
        dram_data_i  = '0;
        dram_empty_i = 1'b1;
        smem_data_i  = '0;
        smem_sel_i   = '0;
        smem_empty_i = 1'b1;
        ready_i      = 1'b0;
        busy         = 1'b0;
        end_seen     = 1'b0;
        proc_done    = 1'b0;
        hold_chk     = 1'b0;
        xfer_cnt     = 0;
        dram_pops    = 0;
        smem_pops    = 0;
        repeat (4) @(posedge clk);
        #2;
        rstn = 1'b1;
        @(negedge clk);
        assert (cfg_ready_o && !valid_o && !dram_pop_o && !smem_pop_o) else
            abort_run($sformatf("error at %0t: idle outputs wrong after reset", $time));
        for (p = 0; p < NUM_PROCS; p++) begin
            r = $urandom;
            case (r % 3)
                0:       cfg.proc = PROC_MXV;
                1:       cfg.proc = PROC_MTXV;
                default: cfg.proc = PROC_VXV;
            endcase
            r        = $urandom;
            cfg.cnt0 = {{(CNT_W-2){1'b0}}, r[1:0]};
            cfg.cnt1 = {{(CNT_W-2){1'b0}}, r[3:2]};
            cfg.cnt2 = {{(CNT_W-2){1'b0}}, r[5:4]};
            n_dram   = (cfg.cnt1 + 1) * (cfg.cnt2 + 1);
            n_beats  = (cfg.cnt0 + 1) * n_dram;
            fill_fifos(cfg);
            build_expected(cfg);
            xfer_cnt  = 0;
            dram_pops = 0;
            smem_pops = 0;
            proc_done = 1'b0;
            @(posedge clk);
            #2;
            cfg_valid_i = 1'b1;
            cfg_i       = cfg;
            // junk configs while busy must be dropped
            while (!proc_done) begin
                @(posedge clk);
                #2;
                r           = $urandom;
                cfg_valid_i = (r[2:0] == 3'd0) && !end_seen && !proc_done;
                cfg_i       = r[31:5];
            end
            cfg_valid_i = 1'b0;
            assert (xfer_cnt == n_beats && smem_pops == n_beats && dram_pops == n_dram) else
                abort_run($sformatf(
                    "error at %0t: proc %0d xfer %0d smem %0d dram %0d, expected %0d %0d %0d",
                    $time, p, xfer_cnt, smem_pops, dram_pops, n_beats, n_beats, n_dram));
            @(negedge clk);
        end
        $display("Regression passed");
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT);
        abort_run("timeout: the regression did not finish within the watchdog limit");
    end

endmodule

//--- files.f
+incdir+dv
source/dmx_pkg.sv
source/dmx_loop_cnt.sv
source/dmx_ctrl.sv
source/dmx_datapath.sv
source/ipm_dmx.sv
dv/dmx_tb.sv

//--- source/dmx_ctrl.sv
module dmx_ctrl
    import dmx_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    // configuration
    input  logic      cfg_valid_i,
    input  dmx_cfg_t  cfg_i,
    output logic      cfg_ready_o,
    // fifo status
    input  logic      dram_empty_i,
    input  logic      smem_empty_i,
    input  logic      ready_i,
    // from loop counters
    input  logic      rep_last_i,
    input  logic      beat_last_i,
    // from datapath
    input  logic      drain_done_i,
    // to loop counters and fifos
    output logic      accept_o,
    output logic      dram_pop_o,
    output logic      smem_pop_o,
    // to datapath
    output beat_tag_t issue_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_STREAM
    } state_e;

    state_e   state;
    dmx_cfg_t cfg_q;
    // final beat already accepted
    logic     done_q;
    logic     cfg_take;
    logic     is_bcast;

    // --------------------------------------------------
    // config handshake
    // --------------------------------------------------

    // ready only while idle
    assign cfg_ready_o = (state == ST_IDLE);
    assign cfg_take    = cfg_valid_i && cfg_ready_o;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cfg_q <= '0;
        end else if (cfg_take) begin
            cfg_q <= cfg_i;
        end
    end

    // --------------------------------------------------
    // procedure fsm
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cfg_take) begin
                        state <= ST_SETUP;
                    end
                end
                ST_SETUP: begin
                    // idle procedure has nothing to stream
                    if (cfg_q.proc == PROC_IDLE) begin
                        state <= ST_IDLE;
                    end else begin
                        state <= ST_STREAM;
                    end
                end
                ST_STREAM: begin
                    // last beat left the output
                    if (drain_done_i) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // blocks further accepts while the tail drains
    always_ff @(posedge clk) begin
        if (!rstn || state == ST_SETUP) begin
            done_q <= 1'b0;
        end else if (accept_o && beat_last_i) begin
            done_q <= 1'b1;
        end
    end

    // --------------------------------------------------
    // beat acceptance and pops
    // --------------------------------------------------
    assign accept_o = (state == ST_STREAM) && !done_q
                    && !smem_empty_i && !dram_empty_i && ready_i;

    // one act word per beat
    assign smem_pop_o = accept_o;
    // weight word reused until its last repeat
    assign dram_pop_o = accept_o && rep_last_i;

    // unicast only for the transposed case
    always_comb begin
        case (cfg_q.proc)
            PROC_MXV, PROC_VXV: is_bcast = 1'b1;
            PROC_MTXV:          is_bcast = 1'b0;
            default:            is_bcast = 1'b0;
        endcase
    end

    assign issue_o.valid = accept_o;
    assign issue_o.last  = beat_last_i;
    assign issue_o.bcast = is_bcast;

endmodule

//--- source/dmx_datapath.sv
module dmx_datapath
    import dmx_pkg::*;
(
    input  logic             clk,
    input  logic             rstn,
    input  logic             ready_i,
    input  beat_tag_t        issue_i,
    // fifo heads, valid alongside the issue tag
    input  lane_vec_t        dram_data_i,
    input  lane_vec_t        smem_data_i,
    input  logic [SEL_W-1:0] smem_sel_i,
    // to the array
    output lane_vec_t        dout_weight_o,
    output lane_vec_t        dout_act_o,
    output logic             valid_o,
    output logic             drain_done_o
);

    // tags per stage
    beat_tag_t         s1_tag;
    beat_tag_t         s2_tag;
    beat_tag_t         s3_tag;

    // stage 1 payload
    lane_vec_t         s1_weight;
    lane_vec_t         s1_act;
    logic [LANE_W-1:0] s1_bc_lane;

    // stage 2 payload
    lane_vec_t         s2_weight;
    lane_vec_t         s2_act;

    // stage 3 payload, the output registers
    lane_vec_t         s3_weight;
    lane_vec_t         s3_act;

    // --------------------------------------------------
    // tag pipe
    // --------------------------------------------------

    // whole pipe freezes with ready low
    always_ff @(posedge clk) begin
        if (!rstn) begin
            s1_tag <= '0;
            s2_tag <= '0;
            s3_tag <= '0;
        end else if (ready_i) begin
            s1_tag <= issue_i;
            s2_tag <= s1_tag;
            s3_tag <= s2_tag;
        end
    end

    // --------------------------------------------------
    // stage 1, capture fifo heads
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (ready_i) begin
            s1_weight  <= dram_data_i;
            s1_act     <= smem_data_i;
            // select belongs to this word
            s1_bc_lane <= smem_data_i[smem_sel_i];
        end
    end

    // --------------------------------------------------
    // stage 2, unicast or broadcast
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (ready_i) begin
            s2_weight <= s1_weight;
            if (s1_tag.bcast) begin
                s2_act <= {NUM_PE{s1_bc_lane}};
            end else begin
                s2_act <= s1_act;
            end
        end
    end

    // --------------------------------------------------
    // stage 3, output registers
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (ready_i) begin
            s3_weight <= s2_weight;
            s3_act    <= s2_act;
        end
    end

    assign dout_weight_o = s3_weight;
    assign dout_act_o    = s3_act;
    assign valid_o       = s3_tag.valid;

    // final beat handed over this cycle
    assign drain_done_o  = s3_tag.valid && s3_tag.last && ready_i;

endmodule

//--- source/dmx_loop_cnt.sv
module dmx_loop_cnt
    import dmx_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     clear_i,
    input  logic     accept_i,
    input  dmx_cfg_t lim_i,
    output logic     rep_last_o,
    output logic     beat_last_o
);

    // cnt0 innermost, cnt2 outermost
    logic [CNT_W-1:0] cnt0;
    logic [CNT_W-1:0] cnt1;
    logic [CNT_W-1:0] cnt2;

    // --------------------------------------------------
    // nested counters
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rstn || clear_i) begin
            cnt0 <= '0;
            cnt1 <= '0;
            cnt2 <= '0;
        end else if (accept_i) begin
            if (cnt0 == lim_i.cnt0) begin
                cnt0 <= '0;
                // carry into middle loop
                if (cnt1 == lim_i.cnt1) begin
                    cnt1 <= '0;
                    // carry into outer loop
                    if (cnt2 == lim_i.cnt2) begin
                        cnt2 <= '0;
                    end else begin
                        cnt2 <= cnt2 + 1'b1;
                    end
                end else begin
                    cnt1 <= cnt1 + 1'b1;
                end
            end else begin
                cnt0 <= cnt0 + 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // flags on current counts
    // --------------------------------------------------

    // last use of the current dram word
    assign rep_last_o  = (cnt0 == lim_i.cnt0);
    // final beat of the whole procedure
    assign beat_last_o = rep_last_o
                       && (cnt1 == lim_i.cnt1)
                       && (cnt2 == lim_i.cnt2);

endmodule

//--- source/dmx_pkg.sv
package dmx_pkg;

    // --------------------------------------------------
    // sizes
    // --------------------------------------------------

    // processing-element lanes per operand vector
    localparam int NUM_PE = 16;
    // one lane word
    localparam int LANE_W = 16;
    // loop counters and their limits
    localparam int CNT_W  = 8;
    // lane index carried with each shared-memory word
    localparam int SEL_W  = $clog2(NUM_PE);

    // --------------------------------------------------
    // procedure codes
    // --------------------------------------------------

    // idle config is legal, it only burns the setup cycle
    typedef enum logic [2:0] {
        PROC_IDLE = 3'd0,
        // matrix times vector, activation broadcast
        PROC_MXV  = 3'd1,
        // transposed matrix times vector, activation unicast
        PROC_MTXV = 3'd2,
        // vector times vector, activation broadcast
        PROC_VXV  = 3'd3
    } proc_e;

    // --------------------------------------------------
    // shared structs
    // --------------------------------------------------

    // one operand vector, lane 0 in the low bits
    typedef logic [NUM_PE-1:0][LANE_W-1:0] lane_vec_t;

    // configuration beat
    // beats per procedure = (cnt0+1)(cnt1+1)(cnt2+1)
    typedef struct packed {
        proc_e            proc;
        // innermost, repeats of one dram word
        logic [CNT_W-1:0] cnt0;
        logic [CNT_W-1:0] cnt1;
        // outermost
        logic [CNT_W-1:0] cnt2;
    } dmx_cfg_t;

    // control riding with each beat down the pipe
    typedef struct packed {
        logic valid;
        // final beat of the procedure
        logic last;
        // copy selected act lane to all lanes
        logic bcast;
    } beat_tag_t;

endpackage

//--- source/ipm_dmx.sv
module ipm_dmx
    import dmx_pkg::*;
(
    input  logic             clk,
    input  logic             rstn,
    // configuration beat
    input  logic             cfg_valid_i,
    input  dmx_cfg_t         cfg_i,
    output logic             cfg_ready_o,
    // dram staging fifo, weights
    input  lane_vec_t        dram_data_i,
    input  logic             dram_empty_i,
    output logic             dram_pop_o,
    // shared-memory fifo, activations
    input  lane_vec_t        smem_data_i,
    input  logic [SEL_W-1:0] smem_sel_i,
    input  logic             smem_empty_i,
    output logic             smem_pop_o,
    // operand stream to the array
    output lane_vec_t        dout_weight_o,
    output lane_vec_t        dout_act_o,
    output logic             valid_o,
    input  logic             ready_i
);

    logic      accept;
    logic      rep_last;
    logic      beat_last;
    logic      drain_done;
    beat_tag_t issue;

    // --------------------------------------------------
    // control
    // --------------------------------------------------
    dmx_ctrl u_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .cfg_valid_i  (cfg_valid_i),
        .cfg_i        (cfg_i),
        .cfg_ready_o  (cfg_ready_o),
        .dram_empty_i (dram_empty_i),
        .smem_empty_i (smem_empty_i),
        .ready_i      (ready_i),
        .rep_last_i   (rep_last),
        .beat_last_i  (beat_last),
        .drain_done_i (drain_done),
        .accept_o     (accept),
        .dram_pop_o   (dram_pop_o),
        .smem_pop_o   (smem_pop_o),
        .issue_o      (issue)
    );

    // counters clear in setup, limits straight from the config
    dmx_loop_cnt u_loop_cnt (
        .clk         (clk),
        .rstn        (rstn),
        .clear_i     (u_ctrl.state == u_ctrl.ST_SETUP),
        .accept_i    (accept),
        .lim_i       (u_ctrl.cfg_q),
        .rep_last_o  (rep_last),
        .beat_last_o (beat_last)
    );

    // --------------------------------------------------
    // operand pipeline
    // --------------------------------------------------
    dmx_datapath u_datapath (
        .clk           (clk),
        .rstn          (rstn),
        .ready_i       (ready_i),
        .issue_i       (issue),
        .dram_data_i   (dram_data_i),
        .smem_data_i   (smem_data_i),
        .smem_sel_i    (smem_sel_i),
        .dout_weight_o (dout_weight_o),
        .dout_act_o    (dout_act_o),
        .valid_o       (valid_o),
        .drain_done_o  (drain_done)
    );

endmodule
